/* vlog.f */
hdl/axi_write_pkg.sv
hdl/burst_if.sv
hdl/write_cmd_ctrl.sv
hdl/write_data_streamer.sv
hdl/bresp_credit_tracker.sv
hdl/m_axi_write.sv
testbench/tb_clock_gen.sv
testbench/tb_m_axi_write.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the AXI write master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module tb_m_axi_write -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vtb_m_axi_write
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit $status
fi
exit 0

/* testbench/tb_m_axi_write.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_m_axi_write
	import axi_write_pkg::*;
();
	localparam int NUM_CMDS = 40;
	localparam int MAX_OUT = 2;
	localparam int BURST_MAX = 16;
	localparam logic [31:0] SEED = 32'd27387;
	localparam int TIMEOUT_CYCLES = NUM_CMDS * 255 * 8 + 2000;

	logic m_axi_aclk;
	logic m_axi_aresetn;
	logic [0:0] m_axi_awid;
	logic [31:0] m_axi_awaddr;
	logic [7:0] m_axi_awlen;
	logic [2:0] m_axi_awsize;
	logic [1:0] m_axi_awburst;
	logic m_axi_awlock;
	logic [3:0] m_axi_awcache;
	logic [2:0] m_axi_awprot;
	logic [3:0] m_axi_awregion;
	logic [3:0] m_axi_awqos;
	logic m_axi_awvalid;
	logic m_axi_awready;
	logic [63:0] m_axi_wdata;
	logic [7:0] m_axi_wstrb;
	logic m_axi_wlast;
	logic m_axi_wvalid;
	logic m_axi_wready;
	logic [0:0] m_axi_bid;
	logic [1:0] m_axi_bresp;
	logic m_axi_bvalid;
	logic m_axi_bready;
	logic m_axi_bresp_err;
	logic cmd_rd_en;
	logic [29:0] cmd_rd_data;
	logic cmd_empty_n;
	logic fifo_rd_en;
	logic [63:0] fifo_rd_data;
	logic fifo_empty_n;
	logic done_wr_en;
	done_rec_t done_wr_data;
	logic done_wr_rdy_n;

	// models and scoreboard
	logic [31:0] rng;
	logic [29:0] cmd_words [2*NUM_CMDS];
	done_rec_t exp_done [NUM_CMDS];
	logic [31:0] exp_addr_q [$];
	logic [7:0] exp_len_q [$];
	logic burst_last_q [$];   // burst closes its command
	int exp_beats_total;
	int total_bursts;
	int err_burst;
	int cmd_ptr;
	int fifo_level;
	logic [63:0] pop_count;   // value at the head of the data FIFO
	int aw_idx;
	int w_burst;
	int w_beat;
	int beats_seen;
	int b_sent;
	int cmds_data_done;
	int done_count;
	int outstanding;
	int cycle;
	logic exp_err;
	logic aw_hs;
	logic w_hs;
	logic w_last_hs;
	logic b_hs;
	logic b_err_now;
	logic cmd_pop;
	logic done_seen;
	logic aw_wait;
	logic w_wait;
	logic [31:0] prev_awaddr;
	logic [7:0] prev_awlen;
	logic [63:0] prev_wdata;
	logic prev_wlast;

	tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(2)) tb_clock_gen_inst (
		.m_axi_aclk(m_axi_aclk),
		.m_axi_aresetn(m_axi_aresetn)
	);

	m_axi_write m_axi_write_inst (
		.m_axi_aclk(m_axi_aclk),
		.m_axi_aresetn(m_axi_aresetn),
		.m_axi_awid(m_axi_awid),
		.m_axi_awaddr(m_axi_awaddr),
		.m_axi_awlen(m_axi_awlen),
		.m_axi_awsize(m_axi_awsize),
		.m_axi_awburst(m_axi_awburst),
		.m_axi_awlock(m_axi_awlock),
		.m_axi_awcache(m_axi_awcache),
		.m_axi_awprot(m_axi_awprot),
		.m_axi_awregion(m_axi_awregion),
		.m_axi_awqos(m_axi_awqos),
		.m_axi_awvalid(m_axi_awvalid),
		.m_axi_awready(m_axi_awready),
		.m_axi_wdata(m_axi_wdata),
		.m_axi_wstrb(m_axi_wstrb),
		.m_axi_wlast(m_axi_wlast),
		.m_axi_wvalid(m_axi_wvalid),
		.m_axi_wready(m_axi_wready),
		.m_axi_bid(m_axi_bid),
		.m_axi_bresp(m_axi_bresp),
		.m_axi_bvalid(m_axi_bvalid),
		.m_axi_bready(m_axi_bready),
		.m_axi_bresp_err(m_axi_bresp_err),
		.cmd_rd_en(cmd_rd_en),
		.cmd_rd_data(cmd_rd_data),
		.cmd_empty_n(cmd_empty_n),
		.fifo_rd_en(fifo_rd_en),
		.fifo_rd_data(fifo_rd_data),
		.fifo_empty_n(fifo_empty_n),
		.done_wr_en(done_wr_en),
		.done_wr_data(done_wr_data),
		.done_wr_rdy_n(done_wr_rdy_n)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function automatic logic chance(input int pct);
		return (next_rand() % 32'd100) < 32'(pct);
	endfunction

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_failure(input string what);
		$display("%s (cycle %0d)", what, cycle);
		abort_run();
	endtask

	task automatic check_aw(input logic [31:0] got_addr, input logic [31:0] want_addr,
			input logic [7:0] got_len, input logic [7:0] want_len);
		if (got_addr !== want_addr) begin
			$display("ERR m_axi_awaddr got %h expected %h", got_addr, want_addr);
			abort_run();
		end
		if (got_len !== want_len) begin
			$display("ERR m_axi_awlen got %h expected %h", got_len, want_len);
			abort_run();
		end
	endtask

	task automatic check_const(input string name, input logic [7:0] got,
			input logic [7:0] want);
		if (got !== want) begin
			$display("ERR %s got %h expected %h", name, got, want);
			abort_run();
		end
	endtask

	task automatic check_beat(input logic [63:0] got_data, input logic [63:0] want_data,
			input logic got_last, input logic want_last);
		if (got_data !== want_data) begin
			$display("ERR m_axi_wdata got %h expected %h", got_data, want_data);
			abort_run();
		end
		if (got_last !== want_last) begin
			$display("ERR m_axi_wlast got %h expected %h", got_last, want_last);
			abort_run();
		end
	endtask

	task automatic check_done(input done_rec_t got, input done_rec_t want);
		if (got !== want) begin
			$display("ERR done_wr_data got %h expected %h", got, want);
			abort_run();
		end
	endtask

	task automatic check_err(input logic got, input logic want);
		if (got !== want) begin
			$display("ERR m_axi_bresp_err got %h expected %h", got, want);
			abort_run();
		end
	endtask

	task automatic build_commands();
		cmd_hdr_t hdr;
		cmd_addr_t addr;
		logic [31:0] r;
		logic [31:0] byte_addr;
		int rem;
		int beats;
		for (int i = 0; i < NUM_CMDS; i++) begin
			r = next_rand();
			hdr = '0;
			hdr.auto_cpl = r[0];
			hdr.cmd_type = r[1];
			hdr.done_check = r[2];
			hdr.slot_tag = r[12:3];
			hdr.len_beats = 8'(1 + (r[31:16] % 16'd255));
			if (i == 0)
				hdr.len_beats = 8'd16;   // exactly one full burst
			else if (i == 1)
				hdr.len_beats = 8'd255;
			r = next_rand();
			addr = '0;
			addr.beat_addr = r[28:0];
			cmd_words[2*i] = hdr;
			cmd_words[2*i+1] = addr;
			exp_done[i].auto_cpl = hdr.auto_cpl;
			exp_done[i].cmd_type = hdr.cmd_type;
			exp_done[i].done_check = hdr.done_check;
			exp_done[i].slot_tag = hdr.slot_tag;
			exp_done[i].len_beats = hdr.len_beats;
			byte_addr = {r[28:0], 3'b000};
			rem = int'(hdr.len_beats);
			while (rem > 0) begin
				beats = (rem > BURST_MAX) ? BURST_MAX : rem;
				exp_addr_q.push_back(byte_addr);
				exp_len_q.push_back(8'(beats - 1));
				burst_last_q.push_back(rem == beats);
				byte_addr = byte_addr + 32'(beats * BEAT_BYTES);
				rem = rem - beats;
			end
			exp_beats_total += int'(hdr.len_beats);
		end
		total_bursts = exp_addr_q.size();
		err_burst = total_bursts - 2;   // one bad response near the end
	endtask

	// sampled mid-cycle, handshakes complete at the next rising edge
	task automatic observe();
		logic want_last;
		cycle++;
		if (cycle >= TIMEOUT_CYCLES)
			report_failure("timeout before all completion records were written");
		check_err(m_axi_bresp_err, exp_err);
		if (aw_wait) begin
			if (!m_axi_awvalid)
				report_failure("awvalid dropped before awready");
			check_aw(m_axi_awaddr, prev_awaddr, m_axi_awlen, prev_awlen);
		end
		if (w_wait) begin
			if (!m_axi_wvalid)
				report_failure("wvalid dropped before wready");
			check_beat(m_axi_wdata, prev_wdata, m_axi_wlast, prev_wlast);
		end
		aw_hs = m_axi_awvalid && m_axi_awready;
		if (m_axi_awvalid) begin
			if (aw_idx >= total_bursts)
				report_failure("more AW requests than bursts in the commands");
			check_aw(m_axi_awaddr, exp_addr_q[aw_idx], m_axi_awlen, exp_len_q[aw_idx]);
			check_const("m_axi_awid", 8'(m_axi_awid), 8'h00);
			check_const("m_axi_awsize", 8'(m_axi_awsize), 8'h03);   // 8 bytes per beat
			check_const("m_axi_awburst", 8'(m_axi_awburst), 8'h01);   // INCR
			check_const("m_axi_awlock", 8'(m_axi_awlock), 8'h00);
			check_const("m_axi_awcache", 8'(m_axi_awcache), 8'h00);
			check_const("m_axi_awprot", 8'(m_axi_awprot), 8'h00);
			check_const("m_axi_awregion", 8'(m_axi_awregion), 8'h00);
			check_const("m_axi_awqos", 8'(m_axi_awqos), 8'h00);
		end
		w_hs = m_axi_wvalid && m_axi_wready;
		w_last_hs = w_hs && m_axi_wlast;
		if (fifo_rd_en !== w_hs)
			report_failure("fifo_rd_en does not match the W handshake");
		if (m_axi_wvalid) begin
			if (w_burst >= aw_idx)
				report_failure("W beat without an issued AW");
			want_last = (w_beat == int'(exp_len_q[w_burst]));
			check_beat(m_axi_wdata, pop_count, m_axi_wlast, want_last);
			check_const("m_axi_wstrb", m_axi_wstrb, 8'hff);   // all bytes written
		end
		if (m_axi_bready !== 1'b1)
			report_failure("bready is not held high");
		b_hs = m_axi_bvalid;
		b_err_now = m_axi_bvalid && (m_axi_bresp != resp_okay);
		if (outstanding + int'(aw_hs) - int'(b_hs) > MAX_OUT)
			report_failure("more than two bursts waiting for a write response");
		cmd_pop = cmd_rd_en;
		if (cmd_rd_en && cmd_ptr >= 2 * NUM_CMDS)
			report_failure("command read while the command FIFO is empty");
		done_seen = done_wr_en;
		if (done_wr_en) begin
			if (done_wr_rdy_n)
				report_failure("done_wr_en while done_wr_rdy_n is high");
			if (done_count >= cmds_data_done)
				report_failure("completion record before the final beat of its command");
			check_done(done_wr_data, exp_done[done_count]);
		end
		aw_wait = m_axi_awvalid && !m_axi_awready;
		prev_awaddr = m_axi_awaddr;
		prev_awlen = m_axi_awlen;
		w_wait = m_axi_wvalid && !m_axi_wready;
		prev_wdata = m_axi_wdata;
		prev_wlast = m_axi_wlast;
	endtask

	task automatic drive();
		if (aw_hs)
			aw_idx++;
		if (w_hs) begin
			pop_count++;
			fifo_level--;
			beats_seen++;
			if (w_last_hs) begin
				if (burst_last_q[w_burst])
					cmds_data_done++;
				w_burst++;
				w_beat = 0;
			end else
				w_beat++;
		end
		if (b_hs) begin
			b_sent++;
			if (b_err_now)
				exp_err = 1'b1;
		end
		outstanding = outstanding + int'(aw_hs) - int'(b_hs);
		if (cmd_pop)
			cmd_ptr++;
		if (done_seen)
			done_count++;

		m_axi_awready = chance(70);
		m_axi_wready = chance(70);
		if (fifo_level < 8 && chance(60))
			fifo_level++;   // producer side of the data FIFO
		fifo_empty_n = (fifo_level > 0);
		fifo_rd_data = pop_count;
		cmd_empty_n = (cmd_ptr < 2 * NUM_CMDS);
		if (cmd_ptr < 2 * NUM_CMDS)
			cmd_rd_data = cmd_words[cmd_ptr];
		else
			cmd_rd_data = '0;
		done_wr_rdy_n = chance(30);
		// B only for bursts whose data is complete
		if (b_sent < w_burst && chance(35)) begin
			m_axi_bvalid = 1'b1;
			m_axi_bresp = (b_sent == err_burst) ? 2'b10 : resp_okay;
		end else begin
			m_axi_bvalid = 1'b0;
			m_axi_bresp = resp_okay;
		end
	endtask

	initial begin
		rng = SEED;
		exp_beats_total = 0;
		build_commands();
		{cmd_ptr, fifo_level, aw_idx, w_burst, w_beat, beats_seen} = '0;
		{b_sent, cmds_data_done, done_count, outstanding, cycle} = '0;
		pop_count = '0;
		exp_err = 1'b0;
		aw_wait = 1'b0;
		w_wait = 1'b0;
		m_axi_awready = 1'b0;
		m_axi_wready = 1'b0;
		m_axi_bid = '0;
		m_axi_bresp = resp_okay;
		m_axi_bvalid = 1'b0;
		cmd_rd_data = '0;
		cmd_empty_n = 1'b0;
		fifo_rd_data = '0;
		fifo_empty_n = 1'b0;
		done_wr_rdy_n = 1'b1;

		@(negedge m_axi_aclk);
		if (m_axi_awvalid || m_axi_wvalid || cmd_rd_en || fifo_rd_en || done_wr_en
				|| m_axi_bresp_err)
			report_failure("an output is not low during reset");
		wait (m_axi_aresetn === 1'b1);

		while (!(done_count == NUM_CMDS && b_sent == total_bursts)) begin
			@(negedge m_axi_aclk);
			observe();
			@(posedge m_axi_aclk);
			#1;
			drive();
		end
		// a few idle cycles, error flag must hold
		repeat (8) begin
			@(negedge m_axi_aclk);
			observe();
			@(posedge m_axi_aclk);
			#1;
			drive();
		end

		if (beats_seen == exp_beats_total && aw_idx == total_bursts && exp_err
				&& m_axi_bresp_err && done_count == NUM_CMDS) begin
			$display("Simulation completed successfully");
			$finish;
		end else
			report_failure("end of run totals do not match the commands");
	end

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS = 10,
	parameter int RESET_CYCLES = 2
) (
	output logic m_axi_aclk,
	output logic m_axi_aresetn
);
	initial begin
		m_axi_aclk = 1'b0;
		forever #(PERIOD_NS / 2) m_axi_aclk = ~m_axi_aclk;
	end

	initial begin
		m_axi_aresetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge m_axi_aclk);
		#1 m_axi_aresetn = 1'b1;   // released just after the edge
	end
endmodule

`default_nettype wire

/* hdl/m_axi_write.sv */
`timescale 1ns/1ps
`default_nettype none

module m_axi_write
	import axi_write_pkg::*;
#(
	parameter int DATA_W = 64,
	parameter int ADDR_W = 32,
	parameter int ID_W = 1,
	parameter int MAX_BURST_BEATS = 16,
	parameter int MAX_OUTSTANDING = 2,
	parameter int QUEUE_DEPTH = 2
) (
	input logic m_axi_aclk,
	input logic m_axi_aresetn,

	output logic [ID_W-1:0] m_axi_awid,
	output logic [ADDR_W-1:0] m_axi_awaddr,
	output logic [7:0] m_axi_awlen,
	output logic [2:0] m_axi_awsize,
	output logic [1:0] m_axi_awburst,
	output logic m_axi_awlock,
	output logic [3:0] m_axi_awcache,
	output logic [2:0] m_axi_awprot,
	output logic [3:0] m_axi_awregion,
	output logic [3:0] m_axi_awqos,
	output logic m_axi_awvalid,
	input logic m_axi_awready,

	output logic [DATA_W-1:0] m_axi_wdata,
	output logic [DATA_W/8-1:0] m_axi_wstrb,
	output logic m_axi_wlast,
	output logic m_axi_wvalid,
	input logic m_axi_wready,

	input logic [ID_W-1:0] m_axi_bid,
	input logic [1:0] m_axi_bresp,
	input logic m_axi_bvalid,
	output logic m_axi_bready,
	output logic m_axi_bresp_err,

	output logic cmd_rd_en,
	input logic [29:0] cmd_rd_data,
	input logic cmd_empty_n,

	output logic fifo_rd_en,
	input logic [DATA_W-1:0] fifo_rd_data,
	input logic fifo_empty_n,

	output logic done_wr_en,
	output done_rec_t done_wr_data,
	input logic done_wr_rdy_n
);
	logic can_issue;

	burst_if burst ();

	// fixed AW attributes, full-width beats
	assign m_axi_awid = '0;
	assign m_axi_awsize = axsize_8_bytes;
	assign m_axi_awburst = axburst_incr;
	assign m_axi_awlock = axlock_normal;
	assign m_axi_awcache = axcache_non_cache;
	assign m_axi_awprot = axprot_secure;
	assign m_axi_awregion = '0;
	assign m_axi_awqos = '0;
	assign m_axi_wstrb = '1;
	assign m_axi_bready = 1'b1;

	write_cmd_ctrl #(
		.ADDR_W(ADDR_W),
		.MAX_BURST_BEATS(MAX_BURST_BEATS),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) write_cmd_ctrl_inst (
		.m_axi_aclk(m_axi_aclk),
		.m_axi_aresetn(m_axi_aresetn),
		.cmd_rd_data(cmd_rd_data),
		.cmd_empty_n(cmd_empty_n),
		.cmd_rd_en(cmd_rd_en),
		.awaddr(m_axi_awaddr),
		.awlen(m_axi_awlen),
		.awvalid(m_axi_awvalid),
		.awready(m_axi_awready),
		.can_issue(can_issue),
		.done_wr_en(done_wr_en),
		.done_wr_data(done_wr_data),
		.done_wr_rdy_n(done_wr_rdy_n),
		.burst(burst.ctrl)
	);

	write_data_streamer #(
		.DATA_W(DATA_W),
		.MAX_BURST_BEATS(MAX_BURST_BEATS),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) write_data_streamer_inst (
		.m_axi_aclk(m_axi_aclk),
		.m_axi_aresetn(m_axi_aresetn),
		.fifo_rd_data(fifo_rd_data),
		.fifo_empty_n(fifo_empty_n),
		.fifo_rd_en(fifo_rd_en),
		.wdata(m_axi_wdata),
		.wlast(m_axi_wlast),
		.wvalid(m_axi_wvalid),
		.wready(m_axi_wready),
		.burst(burst.stream)
	);

	bresp_credit_tracker #(
		.ID_W(ID_W),
		.MAX_OUTSTANDING(MAX_OUTSTANDING)
	) bresp_credit_tracker_inst (
		.m_axi_aclk(m_axi_aclk),
		.m_axi_aresetn(m_axi_aresetn),
		.awvalid(m_axi_awvalid),
		.awready(m_axi_awready),
		.bvalid(m_axi_bvalid),
		.bid(m_axi_bid),
		.bresp(m_axi_bresp),
		.can_issue(can_issue),
		.bresp_err(m_axi_bresp_err)
	);

endmodule

`default_nettype wire

/* hdl/bresp_credit_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module bresp_credit_tracker
	import axi_write_pkg::*;
#(
	parameter int ID_W = 1,
	parameter int MAX_OUTSTANDING = 2
) (
	input logic m_axi_aclk,
	input logic m_axi_aresetn,
	input logic awvalid,
	input logic awready,
	input logic bvalid,
	input logic [ID_W-1:0] bid,
	input logic [1:0] bresp,
	output logic can_issue,
	output logic bresp_err
);
	localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

	logic [CNT_W-1:0] outstanding;
	logic aw_hs;
	logic b_hs;

	assign aw_hs = awvalid && awready;
	assign b_hs = bvalid;   // bready is tied high
	assign can_issue = (outstanding < CNT_W'(MAX_OUTSTANDING));

	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn) begin
		if (!m_axi_aresetn) begin
			outstanding <= '0;
			bresp_err <= 1'b0;
		end else begin
			outstanding <= outstanding + CNT_W'(aw_hs) - CNT_W'(b_hs);
			// sticky until reset
			if (b_hs && (bresp != resp_okay || bid != '0))
				bresp_err <= 1'b1;
		end
	end

	a_outstanding_max: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
		aw_hs |=> outstanding <= CNT_W'(MAX_OUTSTANDING));

	a_no_orphan_b: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
		b_hs |-> outstanding != '0);

endmodule

`default_nettype wire

/* hdl/write_data_streamer.sv */
`timescale 1ns/1ps
`default_nettype none

module write_data_streamer
	import axi_write_pkg::*;
#(
	parameter int DATA_W = 64,
	parameter int MAX_BURST_BEATS = 16,
	parameter int QUEUE_DEPTH = 2
) (
	input logic m_axi_aclk,
	input logic m_axi_aresetn,
	input logic [DATA_W-1:0] fifo_rd_data,
	input logic fifo_empty_n,
	output logic fifo_rd_en,
	output logic [DATA_W-1:0] wdata,
	output logic wlast,
	output logic wvalid,
	input logic wready,
	burst_if.stream burst
);
	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
	localparam int BEAT_W = (MAX_BURST_BEATS > 1) ? $clog2(MAX_BURST_BEATS) : 1;

	burst_len_t q_beats [QUEUE_DEPTH];
	logic q_last [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] q_count;
	logic [BEAT_W-1:0] beat_cnt;   // beats accepted in the head burst
	logic w_hs;
	logic burst_done;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// head of the queue is the burst on the wire
	assign wvalid = (q_count != '0) && fifo_empty_n;
	assign wdata = fifo_rd_data;   // fwft, head word already present
	assign wlast = (q_count != '0) && (burst_len_t'(beat_cnt) + 5'd1 == q_beats[rd_ptr]);
	assign w_hs = wvalid && wready;
	assign fifo_rd_en = w_hs;
	assign burst_done = w_hs && wlast;

	assign burst.slot_free = burst_done;
	assign burst.cmd_data_done = burst_done && q_last[rd_ptr];

	always_ff @(posedge m_axi_aclk) begin
		if (burst.push) begin
			q_beats[wr_ptr] <= burst.beats;
			q_last[wr_ptr] <= burst.cmd_last;
		end
	end

	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn) begin
		if (!m_axi_aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_count <= '0;
			beat_cnt <= '0;
		end else begin
			if (burst.push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (burst_done)
				rd_ptr <= ptr_inc(rd_ptr);
			q_count <= q_count + CNT_W'(burst.push) - CNT_W'(burst_done);
			if (burst_done)
				beat_cnt <= '0;
			else if (w_hs)
				beat_cnt <= beat_cnt + 1'b1;
		end
	end

	a_no_push_full: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
		burst.push |-> q_count != CNT_W'(QUEUE_DEPTH));

	a_wdata_stable: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
		(wvalid && !wready) ##1 wvalid |-> $stable(wdata) && $stable(wlast));

endmodule

`default_nettype wire

/* hdl/write_cmd_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module write_cmd_ctrl
	import axi_write_pkg::*;
#(
	parameter int ADDR_W = 32,
	parameter int MAX_BURST_BEATS = 16,
	parameter int QUEUE_DEPTH = 2
) (
	input logic m_axi_aclk,
	input logic m_axi_aresetn,
	input logic [29:0] cmd_rd_data,
	input logic cmd_empty_n,
	output logic cmd_rd_en,
	output logic [ADDR_W-1:0] awaddr,
	output logic [7:0] awlen,
	output logic awvalid,
	input logic awready,
	input logic can_issue,
	output logic done_wr_en,
	output done_rec_t done_wr_data,
	input logic done_wr_rdy_n,
	burst_if.ctrl burst
);
	localparam int CREDIT_W = $clog2(QUEUE_DEPTH + 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_CMD_HDR,
		S_CMD_ADDR,
		S_AW_REQ,
		S_DATA_WAIT,
		S_RDY_WAIT,
		S_DONE_WR
	} state_t;

	state_t state;
	state_t state_nxt;
	cmd_hdr_t hdr_in;
	cmd_addr_t addr_in;
	cmd_hdr_t hdr_q;
	logic [7:0] rem_beats;
	logic [7:0] burst_beats;
	logic [ADDR_W-1:0] addr_q;
	logic [CREDIT_W-1:0] credits;
	logic aw_hs;
	logic last_burst;

	assign hdr_in = cmd_hdr_t'(cmd_rd_data);
	assign addr_in = cmd_addr_t'(cmd_rd_data);

	// split at MAX_BURST_BEATS
	assign burst_beats = (rem_beats > 8'(MAX_BURST_BEATS)) ? 8'(MAX_BURST_BEATS) : rem_beats;
	assign last_burst = (rem_beats == burst_beats);

	assign cmd_rd_en = (state == S_CMD_HDR) || (state == S_CMD_ADDR);
	assign awaddr = addr_q;
	assign awlen = burst_beats - 8'd1;
	assign awvalid = (state == S_AW_REQ) && (credits != '0) && can_issue;
	assign aw_hs = awvalid && awready;

	assign burst.push = aw_hs;   // descriptor goes with the AW handshake
	assign burst.beats = burst_len_t'(burst_beats);
	assign burst.cmd_last = last_burst;

	assign done_wr_en = (state == S_DONE_WR) && !done_wr_rdy_n;
	assign done_wr_data.auto_cpl = hdr_q.auto_cpl;
	assign done_wr_data.cmd_type = hdr_q.cmd_type;
	assign done_wr_data.done_check = hdr_q.done_check;
	assign done_wr_data.slot_tag = hdr_q.slot_tag;
	assign done_wr_data.len_beats = hdr_q.len_beats;

	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE: if (cmd_empty_n) state_nxt = S_CMD_HDR;
			S_CMD_HDR: state_nxt = S_CMD_ADDR;
			S_CMD_ADDR: state_nxt = S_AW_REQ;
			S_AW_REQ: if (aw_hs && last_burst) state_nxt = S_DATA_WAIT;
			S_DATA_WAIT: if (burst.cmd_data_done) state_nxt = S_RDY_WAIT;
			S_RDY_WAIT: if (!done_wr_rdy_n) state_nxt = S_DONE_WR;
			S_DONE_WR: if (!done_wr_rdy_n) state_nxt = S_IDLE;
			default: state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn) begin
		if (!m_axi_aresetn)
			state <= S_IDLE;
		else
			state <= state_nxt;
	end

	always_ff @(posedge m_axi_aclk) begin
		if (state == S_CMD_HDR) begin
			hdr_q <= hdr_in;
			rem_beats <= hdr_in.len_beats;
		end
		if (state == S_CMD_ADDR)
			addr_q <= ADDR_W'(addr_in.beat_addr) * ADDR_W'(BEAT_BYTES);
		if (aw_hs) begin
			rem_beats <= rem_beats - burst_beats;
			addr_q <= addr_q + ADDR_W'(burst_beats) * ADDR_W'(BEAT_BYTES);
		end
	end

	// slot credits toward the streamer queue
	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn) begin
		if (!m_axi_aresetn)
			credits <= CREDIT_W'(QUEUE_DEPTH);
		else
			credits <= credits + CREDIT_W'(burst.slot_free) - CREDIT_W'(burst.push);
	end

	a_credit_return: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
		burst.slot_free |-> credits != CREDIT_W'(QUEUE_DEPTH));

endmodule

`default_nettype wire

/* hdl/burst_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface burst_if
	import axi_write_pkg::*;
();
	logic push;
	burst_len_t beats;
	logic cmd_last;        // burst closes its command
	logic slot_free;       // one slot credit back
	logic cmd_data_done;

	modport ctrl (
		output push, beats, cmd_last,
		input slot_free, cmd_data_done
	);

	modport stream (
		input push, beats, cmd_last,
		output slot_free, cmd_data_done
	);
endinterface

`default_nettype wire

/* hdl/axi_write_pkg.sv */
`default_nettype none

package axi_write_pkg;

	// AXI encodings
	localparam logic [2:0] axsize_8_bytes = 3'b011;
	localparam logic [1:0] axburst_incr = 2'b01;
	localparam logic axlock_normal = 1'b0;
	localparam logic [3:0] axcache_non_cache = 4'b0000;
	localparam logic [2:0] axprot_secure = 3'b000;   // data, secure, unprivileged
	localparam logic [1:0] resp_okay = 2'b00;

	localparam int SLOT_TAG_W = 10;
	localparam int BEAT_BYTES = 8;

	typedef logic [4:0] burst_len_t;   // 1..16 beats

	// first command word
	typedef struct packed {
		logic [8:0] unused;
		logic auto_cpl;
		logic cmd_type;
		logic done_check;
		logic [SLOT_TAG_W-1:0] slot_tag;
		logic [7:0] len_beats;   // 1..255
	} cmd_hdr_t;

	// second command word, byte address is beat_addr * 8
	typedef struct packed {
		logic unused;
		logic [28:0] beat_addr;
	} cmd_addr_t;

	typedef struct packed {
		logic auto_cpl;
		logic cmd_type;
		logic done_check;
		logic [SLOT_TAG_W-1:0] slot_tag;
		logic [7:0] len_beats;
	} done_rec_t;

endpackage

`default_nettype wire
